/* rtl/ftdi_245fifo_fsm.sv */
// FT600 bus FSM; reads win over writes, rd_n and wr_n are combinational from the status pins
`timescale 1ns/100ps

module ftdi_245fifo_fsm (
    input  logic                            ftdi_clk,
    input  logic                            i_rst_n,
    stream_if.snk                           tx,
    stream_if.src                           rx,
    input  logic                            i_rx_almost_full,
    input  logic                            i_ftdi_rxf_n,
    input  logic                            i_ftdi_txe_n,
    output logic                            o_ftdi_oe_n,
    output logic                            o_ftdi_rd_n,
    output logic                            o_ftdi_wr_n,
    output logic                            o_ftdi_data_oe,
    output logic [ftdi_bus_pkg::DATA_W-1:0] o_ftdi_data,
    output logic [ftdi_bus_pkg::BE_W-1:0]   o_ftdi_be,
    input  logic [ftdi_bus_pkg::DATA_W-1:0] i_ftdi_data,
    input  logic [ftdi_bus_pkg::BE_W-1:0]   i_ftdi_be
);

    ftdi_bus_pkg::bus_state_e state;
    ftdi_bus_pkg::bus_state_e state_next;

    logic                   rx_ok;
    logic                   tx_ok;
    logic                   rd_fire;
    logic                   wr_fire;
    logic                   oe_n_r;
    logic                   rx_vld_r;
    ftdi_stream_pkg::beat_t rx_beat_r;

    // chip has a word and the rx FIFO still has margin
    assign rx_ok = (i_ftdi_rxf_n == ftdi_bus_pkg::PIN_ACT) && !i_rx_almost_full;

    // chip has room and a tx word is waiting
    assign tx_ok = (i_ftdi_txe_n == ftdi_bus_pkg::PIN_ACT) && tx.valid;

    // ----------------------------------------
    // state machine
    // ----------------------------------------

    always_comb begin
        state_next = state;
        unique case (state)
            ftdi_bus_pkg::ST_IDLE: begin
                if (rx_ok) begin
                    state_next = ftdi_bus_pkg::ST_TURN;
                end else if (tx_ok) begin
                    state_next = ftdi_bus_pkg::ST_WRITE;
                end
            end
            ftdi_bus_pkg::ST_TURN: begin
                // chip drives the bus from now on
                state_next = rx_ok ? ftdi_bus_pkg::ST_READ : ftdi_bus_pkg::ST_IDLE;
            end
            ftdi_bus_pkg::ST_READ: begin
                if (!rx_ok) begin
                    state_next = ftdi_bus_pkg::ST_IDLE;
                end
            end
            ftdi_bus_pkg::ST_WRITE: begin
                if (!tx_ok) begin
                    state_next = ftdi_bus_pkg::ST_IDLE;
                end
            end
            default: begin
                state_next = ftdi_bus_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge ftdi_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= ftdi_bus_pkg::ST_IDLE;
            oe_n_r   <= ftdi_bus_pkg::PIN_IDLE;
            rx_vld_r <= 1'b0;
        end else begin
            state <= state_next;
            // oe_n falls entering ST_TURN and rises on the way back to idle
            if (state_next == ftdi_bus_pkg::ST_TURN || state_next == ftdi_bus_pkg::ST_READ) begin
                oe_n_r <= ftdi_bus_pkg::PIN_ACT;
            end else begin
                oe_n_r <= ftdi_bus_pkg::PIN_IDLE;
            end
            rx_vld_r <= rd_fire;
        end
    end

    // ----------------------------------------
    // data paths
    // ----------------------------------------

    assign rd_fire = (state == ftdi_bus_pkg::ST_READ) && rx_ok;
    assign wr_fire = (state == ftdi_bus_pkg::ST_WRITE) && tx_ok;

    // word read from the chip, pushed into the rx FIFO one edge later
    always_ff @(posedge ftdi_clk) begin
        if (rd_fire) begin
            rx_beat_r.data <= i_ftdi_data;
            rx_beat_r.keep <= i_ftdi_be;
        end
    end

    // rx.ready is not looked at, almost-full throttles reads instead
    assign rx.valid = rx_vld_r;
    assign rx.beat  = rx_beat_r;

    // tx word leaves the FIFO in the same cycle the chip takes it
    assign tx.ready = wr_fire;

    assign o_ftdi_oe_n    = oe_n_r;
    assign o_ftdi_rd_n    = rd_fire ? ftdi_bus_pkg::PIN_ACT : ftdi_bus_pkg::PIN_IDLE;
    assign o_ftdi_wr_n    = wr_fire ? ftdi_bus_pkg::PIN_ACT : ftdi_bus_pkg::PIN_IDLE;
    assign o_ftdi_data_oe = (state == ftdi_bus_pkg::ST_WRITE);
    assign o_ftdi_data    = tx.beat.data;
    assign o_ftdi_be      = tx.beat.keep;

    // ----------------------------------------
    // bus rules
    // ----------------------------------------

    // both sides must never drive the data lines at once
    a_no_contention : assert property (
        @(posedge ftdi_clk) disable iff (!i_rst_n)
        !(o_ftdi_data_oe && o_ftdi_oe_n == ftdi_bus_pkg::PIN_ACT)
    ) else $error("ftdi_245fifo_fsm: data_oe high while oe_n low");

    a_rd_wr_excl : assert property (
        @(posedge ftdi_clk) disable iff (!i_rst_n)
        !(o_ftdi_rd_n == ftdi_bus_pkg::PIN_ACT && o_ftdi_wr_n == ftdi_bus_pkg::PIN_ACT)
    ) else $error("ftdi_245fifo_fsm: rd_n and wr_n low together");

endmodule

/* rtl/ftdi_245fifo_top.sv */
// FT600 245-FIFO controller; user streams run on ftdi_clk, data lines are split into in/out/oe
`timescale 1ns/100ps

module ftdi_245fifo_top #(
    parameter int TX_EA = ftdi_stream_pkg::TX_EA_DEF,
    parameter int RX_EA = ftdi_stream_pkg::RX_EA_DEF
) (
    input  logic                            ftdi_clk,
    input  logic                            i_rst_n,
    // user send stream
    input  logic                            i_tx_tvalid,
    output logic                            o_tx_tready,
    input  logic [ftdi_bus_pkg::DATA_W-1:0] i_tx_tdata,
    input  logic [ftdi_bus_pkg::BE_W-1:0]   i_tx_tkeep,
    // user receive stream
    output logic                            o_rx_tvalid,
    input  logic                            i_rx_tready,
    output logic [ftdi_bus_pkg::DATA_W-1:0] o_rx_tdata,
    output logic [ftdi_bus_pkg::BE_W-1:0]   o_rx_tkeep,
    // chip pins
    input  logic                            i_ftdi_rxf_n,
    input  logic                            i_ftdi_txe_n,
    output logic                            o_ftdi_oe_n,
    output logic                            o_ftdi_rd_n,
    output logic                            o_ftdi_wr_n,
    output logic                            o_ftdi_data_oe,
    output logic [ftdi_bus_pkg::DATA_W-1:0] o_ftdi_data,
    output logic [ftdi_bus_pkg::BE_W-1:0]   o_ftdi_be,
    input  logic [ftdi_bus_pkg::DATA_W-1:0] i_ftdi_data,
    input  logic [ftdi_bus_pkg::BE_W-1:0]   i_ftdi_be
);

    logic rx_almost_full;

    stream_if tx_user_if ();
    stream_if tx_if ();
    stream_if rx_if ();
    stream_if rx_user_if ();

    // ----------------------------------------
    // user ports
    // ----------------------------------------

    assign tx_user_if.valid     = i_tx_tvalid;
    assign tx_user_if.beat.data = i_tx_tdata;
    assign tx_user_if.beat.keep = i_tx_tkeep;
    assign o_tx_tready          = tx_user_if.ready;

    assign o_rx_tvalid      = rx_user_if.valid;
    assign o_rx_tdata       = rx_user_if.beat.data;
    assign o_rx_tkeep       = rx_user_if.beat.keep;
    assign rx_user_if.ready = i_rx_tready;

    // ----------------------------------------
    // FIFO -> bus FSM -> FIFO
    // ----------------------------------------

    // tx almost-full has no user here
    stream_fifo #(
        .EA        (TX_EA),
        .AF_MARGIN (ftdi_stream_pkg::AF_MARGIN_DEF)
    ) u_tx_fifo (
        .i_clk         (ftdi_clk),
        .i_rst_n       (i_rst_n),
        .s             (tx_user_if.snk),
        .m             (tx_if.src),
        .o_almost_full ()
    );

    ftdi_245fifo_fsm u_fsm (
        .ftdi_clk         (ftdi_clk),
        .i_rst_n          (i_rst_n),
        .tx               (tx_if.snk),
        .rx               (rx_if.src),
        .i_rx_almost_full (rx_almost_full),
        .i_ftdi_rxf_n     (i_ftdi_rxf_n),
        .i_ftdi_txe_n     (i_ftdi_txe_n),
        .o_ftdi_oe_n      (o_ftdi_oe_n),
        .o_ftdi_rd_n      (o_ftdi_rd_n),
        .o_ftdi_wr_n      (o_ftdi_wr_n),
        .o_ftdi_data_oe   (o_ftdi_data_oe),
        .o_ftdi_data      (o_ftdi_data),
        .o_ftdi_be        (o_ftdi_be),
        .i_ftdi_data      (i_ftdi_data),
        .i_ftdi_be        (i_ftdi_be)
    );

    stream_fifo #(
        .EA        (RX_EA),
        .AF_MARGIN (ftdi_stream_pkg::AF_MARGIN_DEF)
    ) u_rx_fifo (
        .i_clk         (ftdi_clk),
        .i_rst_n       (i_rst_n),
        .s             (rx_if.snk),
        .m             (rx_user_if.src),
        .o_almost_full (rx_almost_full)
    );

endmodule

/* rtl/ftdi_bus_pkg.sv */
// FT600 bus only (16 data bits, 2 byte enables); all chip control pins are active low
package ftdi_bus_pkg;

    // ----------------------------------------
    // bus geometry
    // ----------------------------------------

    // log2 of bus width in bytes, FT600 is a 2-byte bus
    localparam int CHIP_EW = 1;

    // data bits and byte enables on the chip bus
    localparam int DATA_W = 8 << CHIP_EW;
    localparam int BE_W   = 1 << CHIP_EW;

    // ----------------------------------------
    // pin levels
    // ----------------------------------------

    // rxf_n, txe_n, oe_n, rd_n and wr_n all use these
    localparam logic PIN_ACT  = 1'b0;
    localparam logic PIN_IDLE = 1'b1;

    // bus FSM states
    // ST_TURN is the one idle cycle where the chip takes over the data lines
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_TURN,
        ST_READ,
        ST_WRITE
    } bus_state_e;

endpackage

/* rtl/ftdi_stream_pkg.sv */
// stream beats are one chip word wide; FIFO depths are powers of two, margin must stay below depth
package ftdi_stream_pkg;

    // one FIFO entry, matches the chip word one to one
    typedef struct packed {
        logic [ftdi_bus_pkg::DATA_W-1:0] data;
        logic [ftdi_bus_pkg::BE_W-1:0]   keep;
    } beat_t;

    // ----------------------------------------
    // FIFO defaults
    // ----------------------------------------

    // log2 of the FIFO depths, 16 entries each
    localparam int TX_EA_DEF = 4;
    localparam int RX_EA_DEF = 4;

    // free entries left when almost-full rises
    // the bus FSM may still land this many words after it sees the flag
    localparam int AF_MARGIN_DEF = 2;

endpackage

/* rtl/stream_fifo.sv */
// single-clock show-ahead FIFO; flags are registered, so ready and valid are low on the first edge
`timescale 1ns/100ps

module stream_fifo #(
    parameter int EA        = ftdi_stream_pkg::TX_EA_DEF,
    parameter int AF_MARGIN = ftdi_stream_pkg::AF_MARGIN_DEF
) (
    input  logic  i_clk,
    input  logic  i_rst_n,
    stream_if.snk s,
    stream_if.src m,
    output logic  o_almost_full
);

    localparam logic [EA:0] DEPTH   = {1'b1, {EA{1'b0}}};
    localparam logic [EA:0] PTR_ONE = {{EA{1'b0}}, 1'b1};
    localparam logic [EA:0] AF_FILL = DEPTH - (EA + 1)'(AF_MARGIN);

    ftdi_stream_pkg::beat_t mem [0:(1 << EA)-1];

    // pointers carry one extra wrap bit
    logic [EA:0] wr_ptr;
    logic [EA:0] rd_ptr;
    logic [EA:0] occ;
    logic [EA:0] occ_next;

    logic push;
    logic pop;
    logic rdy_r;
    logic vld_r;

    // ----------------------------------------
    // occupancy
    // ----------------------------------------

    assign push = s.valid && rdy_r;
    assign pop  = vld_r && m.ready;

    assign occ      = wr_ptr - rd_ptr;
    assign occ_next = occ + {{EA{1'b0}}, push} - {{EA{1'b0}}, pop};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            rdy_r         <= 1'b0;
            vld_r         <= 1'b0;
            o_almost_full <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_ONE;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_ONE;
            end
            // flags follow the occupancy after this edge
            rdy_r         <= (occ_next != DEPTH);
            vld_r         <= (occ_next != '0);
            o_almost_full <= (occ_next >= AF_FILL);
        end
    end

    // ----------------------------------------
    // storage
    // ----------------------------------------

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr[EA-1:0]] <= s.beat;
        end
    end

    // head entry is shown before it is popped
    assign s.ready = rdy_r;
    assign m.valid = vld_r;
    assign m.beat  = mem[rd_ptr[EA-1:0]];

    // ----------------------------------------
    // checks
    // ----------------------------------------

    // registered flags must agree with the pointers
    a_no_push_full : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        push |-> (occ != DEPTH)
    ) else $error("stream_fifo: push while full");

    a_no_pop_empty : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        pop |-> (occ != '0)
    ) else $error("stream_fifo: pop while empty");

    // a refused beat has to be offered again unchanged, or it is lost
    a_src_holds : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (s.valid && !s.ready) |=> (s.valid && $stable(s.beat))
    ) else $error("stream_fifo: beat dropped by source before it was taken");

endmodule

/* rtl/stream_if.sv */
// one valid/ready stream on a single clock; source must hold valid and beat until accepted
`timescale 1ns/100ps

interface stream_if;

    // transfer on every edge where valid and ready are both high
    logic                   valid;
    logic                   ready;
    ftdi_stream_pkg::beat_t beat;

    // producing side
    modport src (
        output valid,
        output beat,
        input  ready
    );

    // consuming side
    modport snk (
        input  valid,
        input  beat,
        output ready
    );

endinterface

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f src.f \
    --top-module ftdi_245fifo_tb && ./obj_dir/Vftdi_245fifo_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -sqx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* src.f */
rtl/ftdi_bus_pkg.sv
rtl/ftdi_stream_pkg.sv
rtl/stream_if.sv
rtl/stream_fifo.sv
rtl/ftdi_245fifo_fsm.sv
rtl/ftdi_245fifo_top.sv
verification/ftdi_245fifo_checker.sv
verification/ftdi_245fifo_tb.sv

/* verification/ftdi_245fifo_checker.sv */
// samples at the falling edge, 40 ns after the testbench drives, when every port is settled
`timescale 1ns/100ps

module ftdi_245fifo_checker #(
    parameter int EW       = 18,
    parameter int MAX_N    = 64,
    parameter int TX_DEPTH = 4
) (
    input  logic                            ftdi_clk,
    input  logic                            i_rst_n,
    input  logic                            i_tx_tvalid,
    input  logic                            o_tx_tready,
    input  logic                            o_rx_tvalid,
    input  logic                            i_rx_tready,
    input  logic [ftdi_bus_pkg::DATA_W-1:0] o_rx_tdata,
    input  logic [ftdi_bus_pkg::BE_W-1:0]   o_rx_tkeep,
    input  logic                            i_ftdi_txe_n,
    input  logic                            o_ftdi_oe_n,
    input  logic                            o_ftdi_rd_n,
    input  logic                            o_ftdi_wr_n,
    input  logic                            o_ftdi_data_oe,
    input  logic [ftdi_bus_pkg::DATA_W-1:0] o_ftdi_data,
    input  logic [ftdi_bus_pkg::BE_W-1:0]   o_ftdi_be,
    input  logic [EW-1:0]                   i_tx_list [0:MAX_N-1],
    input  logic [EW-1:0]                   i_rx_list [0:MAX_N-1],
    input  int                              i_n_tx,
    input  int                              i_n_rx,
    output logic                            o_done,
    output int                              o_errors
);

    int   errors       = 0;
    int   tx_seen      = 0;
    int   rx_seen      = 0;
    int   tx_occ       = 0;
    logic tx_full_seen = 1'b0;
    logic in_reset     = 1'b1;
    logic done_r       = 1'b0;

    task automatic count_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic compare_word(input string path, input int idx, input logic [EW-1:0] got,
                                input logic [EW-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s word %0d is %h, expected %h", $time, path, idx, got, exp);
            errors++;
        end
    endtask

    always @(negedge ftdi_clk) begin
        if (in_reset) begin
            // holds through reset and up to the first edge after release
            if (!o_ftdi_oe_n || !o_ftdi_rd_n || !o_ftdi_wr_n || o_ftdi_data_oe
                || o_rx_tvalid || o_tx_tready) begin
                $display("[FAIL] %0t: control pins are not at their reset values", $time);
                errors++;
            end
            in_reset = !i_rst_n;
        end else begin
            if (o_ftdi_data_oe && !o_ftdi_oe_n) begin
                count_error("data_oe is high while oe_n is low, both sides drive the bus");
            end
            if (!o_ftdi_rd_n && !o_ftdi_wr_n) begin
                count_error("rd_n and wr_n are low together");
            end
            if (!o_ftdi_wr_n && i_ftdi_txe_n) begin
                count_error("wr_n is low while the chip reports no room");
            end
            // TX FIFO occupancy from user pushes and bus writes
            if (tx_occ == TX_DEPTH) begin
                tx_full_seen = 1'b1;
                if (o_tx_tready) begin
                    count_error("tx_tready is high while the TX FIFO is full");
                end
            end
            if (i_tx_tvalid && o_tx_tready) begin
                tx_occ++;
            end
            if (!o_ftdi_wr_n && !i_ftdi_txe_n) begin
                tx_occ--;
                if (tx_seen < i_n_tx) begin
                    compare_word("TX", tx_seen, {o_ftdi_data, o_ftdi_be}, i_tx_list[tx_seen]);
                end else begin
                    count_error("the bus wrote more TX words than the golden file holds");
                end
                tx_seen++;
            end
            if (o_rx_tvalid && i_rx_tready) begin
                if (rx_seen < i_n_rx) begin
                    compare_word("RX", rx_seen, {o_rx_tdata, o_rx_tkeep}, i_rx_list[rx_seen]);
                end else begin
                    count_error("the user port gave more RX words than the golden file holds");
                end
                rx_seen++;
            end
            if (!done_r && tx_seen == i_n_tx && rx_seen == i_n_rx) begin
                if (!tx_full_seen) begin
                    count_error("the TX FIFO never filled, so send back-pressure was not exercised");
                end
                done_r = 1'b1;
            end
        end
    end

    assign o_done   = done_r;
    assign o_errors = errors;

endmodule

/* verification/ftdi_245fifo_tb.sv */
// golden words come from verification/ftdi_golden.txt; both FIFOs run at depth 4 so stalls fill them
`timescale 1ns/100ps

module ftdi_245fifo_tb;

    localparam int DW    = ftdi_bus_pkg::DATA_W;
    localparam int BW    = ftdi_bus_pkg::BE_W;
    localparam int EA    = 2;
    localparam int MAX_N = 64;

    logic          ftdi_clk;
    logic          i_rst_n;
    logic          i_tx_tvalid;
    logic          o_tx_tready;
    logic [DW-1:0] i_tx_tdata;
    logic [BW-1:0] i_tx_tkeep;
    logic          o_rx_tvalid;
    logic          i_rx_tready;
    logic [DW-1:0] o_rx_tdata;
    logic [BW-1:0] o_rx_tkeep;
    logic          i_ftdi_rxf_n;
    logic          i_ftdi_txe_n;
    logic          o_ftdi_oe_n;
    logic          o_ftdi_rd_n;
    logic          o_ftdi_wr_n;
    logic          o_ftdi_data_oe;
    logic [DW-1:0] o_ftdi_data;
    logic [BW-1:0] o_ftdi_be;
    logic [DW-1:0] i_ftdi_data;
    logic [BW-1:0] i_ftdi_be;

    logic [DW+BW-1:0] tx_list [0:MAX_N-1];
    logic [DW+BW-1:0] rx_list [0:MAX_N-1];
    int               n_tx = 0;
    int               n_rx = 0;
    int               cycles = 0;
    int               limit;
    int               chk_errors;
    logic             chk_done;
    logic [31:0]      lfsr = 32'hddbf_7856;

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // each line holds T or R, a 16-bit hex word and a 2-bit hex keep
    task automatic load_golden();
        int            fd;
        logic [7:0]    kind;
        logic [DW-1:0] word;
        logic [BW-1:0] keep;
        fd = $fopen("verification/ftdi_golden.txt", "r");
        while (fd != 0 && $fscanf(fd, " %c %h %h", kind, word, keep) == 3) begin
            if (kind == "T" && n_tx < MAX_N) begin
                tx_list[n_tx] = {word, keep};
                n_tx++;
            end else if (kind == "R" && n_rx < MAX_N) begin
                rx_list[n_rx] = {word, keep};
                n_rx++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    initial begin
        ftdi_clk = 1'b0;
        forever #50 ftdi_clk = ~ftdi_clk;
    end

    always @(posedge ftdi_clk) cycles <= cycles + 1;

    ftdi_245fifo_top #(
        .TX_EA (EA),
        .RX_EA (EA)
    ) uut (.*);

    ftdi_245fifo_checker #(
        .EW       (DW + BW),
        .MAX_N    (MAX_N),
        .TX_DEPTH (1 << EA)
    ) u_chk (
        .i_tx_list (tx_list),
        .i_rx_list (rx_list),
        .i_n_tx    (n_tx),
        .i_n_rx    (n_rx),
        .o_done    (chk_done),
        .o_errors  (chk_errors),
        .*
    );

    // ----------------------------------------
    // reset, run and verdict
    // ----------------------------------------

    initial begin
        i_rst_n      = 1'b0;
        i_tx_tvalid  = 1'b0;
        i_tx_tdata   = '0;
        i_tx_tkeep   = '0;
        i_rx_tready  = 1'b0;
        i_ftdi_rxf_n = 1'b1;
        i_ftdi_txe_n = 1'b1;
        i_ftdi_data  = '0;
        i_ftdi_be    = '0;
        load_golden();
        if (n_tx == 0 || n_rx == 0) begin
            $display("no TX or RX entries could be read from verification/ftdi_golden.txt");
        end
        limit = 20 * (n_tx + n_rx) + 200;
        repeat (3) @(posedge ftdi_clk);
        #10;
        i_rst_n = 1'b1;
        while (!chk_done && cycles < limit) begin
            @(posedge ftdi_clk);
        end
        if (!chk_done) begin
            $display("run timed out after %0d cycles with golden words still pending", cycles);
        end
        $display("%0d errors, %0d TX and %0d RX golden words", chk_errors, n_tx, n_rx);
        if (chk_done && chk_errors == 0 && n_tx > 0 && n_rx > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ----------------------------------------
    // user tx source and FT600 model
    // ----------------------------------------

    initial begin
        logic tx_took;
        logic rd_took;
        logic stall;
        logic b0;
        int   tx_pos;
        int   chip_pos;
        tx_pos   = 0;
        chip_pos = 0;
        wait (i_rst_n);
        forever begin
            // handshakes are settled at the falling edge
            @(negedge ftdi_clk);
            tx_took = i_tx_tvalid && o_tx_tready;
            rd_took = !o_ftdi_rd_n && !i_ftdi_rxf_n;
            @(posedge ftdi_clk);
            #10;
            if (tx_took) begin
                tx_pos++;
            end
            if (rd_took) begin
                chip_pos++;
            end
            i_tx_tvalid = (tx_pos < n_tx);
            if (tx_pos < n_tx) begin
                {i_tx_tdata, i_tx_tkeep} = tx_list[tx_pos];
            end
            // chip shows its next word until the FSM strobes rd_n
            i_ftdi_rxf_n = (chip_pos >= n_rx);
            if (chip_pos < n_rx) begin
                {i_ftdi_data, i_ftdi_be} = rx_list[chip_pos];
            end
            // long hold-off at the start so both FIFOs fill
            stall = (cycles < 30);
            lfsr  = lfsr_next(lfsr);
            b0    = lfsr[0];
            lfsr  = lfsr_next(lfsr);
            i_ftdi_txe_n = stall || (b0 && lfsr[0]);
            lfsr  = lfsr_next(lfsr);
            i_rx_tready  = !stall && lfsr[0];
        end
    end

endmodule

/* verification/ftdi_golden.txt */
T 1a2b 3
T c0de 3
T 0055 1
T aa00 2
T 7e81 3
T ffff 3
R 3c4d 3
R 0001 1
R beef 3
R 8000 2
R 5a5a 3
R 0f0f 3
